// File: Makefile
# Verilator build and run of the decimation subsystem testbench.
# Every variable can be overridden on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP ?= decimation_subsystem_tb
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VERILATOR_FLAGS SIM_ARGS"

# The simulator's exit status is the test result
test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
source/decimation_pkg.sv
source/decimator_config.sv
source/sample_decimator.sv
source/stream_arbiter.sv
source/decimation_subsystem.sv
tests/decimation_checker.sv
tests/decimation_subsystem_tb.sv

// File: source/decimation_pkg.sv
/* Widths, the sample beat struct and the enums shared by the decimation subsystem.
   Modules import it inside their body and use scoped names in their headers. */

package decimation_pkg;

    // Signed sample width on every stream
    localparam int DATA_WIDTH = 16;

    // Largest ratio as a power of two, also the accumulator headroom
    localparam int MAX_RATIO_LOG2 = 7;

    localparam int RATIO_WIDTH = 3;

    // Wide enough for N_STREAMS * N_CHANNELS global tags at the default sizes
    localparam int TAG_WIDTH = 4;

    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0] tag;
        logic last;
    } sample_beat_t;

    // Sample keeps the closing sample, average emits the floored mean of the group
    typedef enum logic {
        MODE_SAMPLE,
        MODE_AVERAGE
    } decimation_mode_t;

    // Address of a configuration write within one stream
    typedef enum logic {
        FIELD_RATIO,
        FIELD_MODE
    } config_field_t;

endpackage

// File: source/decimation_subsystem.sv
/* Top level of the decimation front end: configuration registers, one decimator
   per input stream and the output arbiter. */
`timescale 1ns/10ps

module decimation_subsystem #(
    parameter int N_STREAMS = 2,
    parameter int N_CHANNELS = 4,
    localparam int STREAM_WIDTH = $clog2(N_STREAMS > 1 ? N_STREAMS : 2)
) (
    input logic clock,
    input logic reset,
    input logic [N_STREAMS-1:0] stream_valid,
    output logic [N_STREAMS-1:0] stream_ready,
    input decimation_pkg::sample_beat_t stream_beat [N_STREAMS],
    input logic config_write,
    input logic [STREAM_WIDTH-1:0] config_stream,
    input decimation_pkg::config_field_t config_field,
    input logic [decimation_pkg::RATIO_WIDTH-1:0] config_value,
    output logic out_valid,
    input logic out_ready,
    output decimation_pkg::sample_beat_t out_beat
);

    import decimation_pkg::*;

    logic [RATIO_WIDTH-1:0] ratio [N_STREAMS];
    decimation_mode_t mode [N_STREAMS];

    logic [N_STREAMS-1:0] dec_valid;
    logic [N_STREAMS-1:0] dec_ready;
    sample_beat_t dec_beat [N_STREAMS];

    decimator_config #(
        .N_STREAMS(N_STREAMS)
    ) decimator_config_inst (
        .clock(clock),
        .reset(reset),
        .config_write(config_write),
        .config_stream(config_stream),
        .config_field(config_field),
        .config_value(config_value),
        .ratio(ratio),
        .mode(mode)
    );

    for (genvar i = 0; i < N_STREAMS; i++) begin : gen_decimator
        sample_decimator #(
            .N_CHANNELS(N_CHANNELS)
        ) sample_decimator_inst (
            .clock(clock),
            .reset(reset),
            .in_valid(stream_valid[i]),
            .in_ready(stream_ready[i]),
            .in_beat(stream_beat[i]),
            .ratio(ratio[i]),
            .mode(mode[i]),
            .out_valid(dec_valid[i]),
            .out_ready(dec_ready[i]),
            .out_beat(dec_beat[i])
        );
    end

    stream_arbiter #(
        .N_STREAMS(N_STREAMS),
        .N_CHANNELS(N_CHANNELS)
    ) stream_arbiter_inst (
        .clock(clock),
        .reset(reset),
        .in_valid(dec_valid),
        .in_ready(dec_ready),
        .in_beat(dec_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_beat(out_beat)
    );

endmodule

// File: source/decimator_config.sv
/* Per-stream ratio and mode registers, updated by a one-cycle write strobe.
   Each stream's decimator reads its ratio and mode as static levels. */
`timescale 1ns/10ps

module decimator_config #(
    parameter int N_STREAMS = 2,
    localparam int STREAM_WIDTH = $clog2(N_STREAMS > 1 ? N_STREAMS : 2)
) (
    input logic clock,
    input logic reset,
    input logic config_write,
    input logic [STREAM_WIDTH-1:0] config_stream,
    input decimation_pkg::config_field_t config_field,
    input logic [decimation_pkg::RATIO_WIDTH-1:0] config_value,
    output logic [decimation_pkg::RATIO_WIDTH-1:0] ratio [N_STREAMS],
    output decimation_pkg::decimation_mode_t mode [N_STREAMS]
);

    import decimation_pkg::*;

    logic [RATIO_WIDTH-1:0] clamped_ratio;
    logic stream_in_range;
    decimation_mode_t written_mode;

    // Ratios beyond the accumulator headroom are limited to the largest one
    assign clamped_ratio = (int'(config_value) > MAX_RATIO_LOG2) ?
                           RATIO_WIDTH'(MAX_RATIO_LOG2) : config_value;

    // Writes to a stream that does not exist are dropped
    assign stream_in_range = int'(config_stream) < N_STREAMS;

    // Bit 0 of the value selects the mode
    assign written_mode = decimation_mode_t'(config_value[0]);

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < N_STREAMS; i++) begin
                ratio[i] <= '0;
                mode[i] <= MODE_SAMPLE;
            end
        end else if (config_write && stream_in_range) begin
            case (config_field)
                FIELD_RATIO: begin
                    ratio[config_stream] <= clamped_ratio;
                end
                FIELD_MODE: begin
                    mode[config_stream] <= written_mode;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/sample_decimator.sv
/* Multi-channel decimator for one stream. Closes groups of 2^ratio beats per channel
   and emits either the closing sample or the floored group mean through a one-beat register. */
`timescale 1ns/10ps

module sample_decimator #(
    parameter int N_CHANNELS = 4
) (
    input logic clock,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input decimation_pkg::sample_beat_t in_beat,
    input logic [decimation_pkg::RATIO_WIDTH-1:0] ratio,
    input decimation_pkg::decimation_mode_t mode,
    output logic out_valid,
    input logic out_ready,
    output decimation_pkg::sample_beat_t out_beat
);

    import decimation_pkg::*;

    localparam int ACC_WIDTH = DATA_WIDTH + MAX_RATIO_LOG2;
    localparam int COUNT_WIDTH = MAX_RATIO_LOG2;
    localparam int CHANNEL_WIDTH = $clog2(N_CHANNELS > 1 ? N_CHANNELS : 2);

    // Per-channel group state, selected by the tag of the incoming beat
    logic [COUNT_WIDTH-1:0] count [N_CHANNELS];
    logic signed [ACC_WIDTH-1:0] accumulator [N_CHANNELS];

    logic [CHANNEL_WIDTH-1:0] channel;
    logic [COUNT_WIDTH-1:0] group_last;
    logic group_end;
    logic accept;
    logic signed [ACC_WIDTH-1:0] extended_sample;
    logic signed [ACC_WIDTH-1:0] group_sum;
    logic signed [ACC_WIDTH-1:0] group_mean;
    logic signed [DATA_WIDTH-1:0] decimated_data;

    assign channel = in_beat.tag[CHANNEL_WIDTH-1:0];

    // The output register can take a new beat when empty or being drained now
    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;

    // Index of the beat that closes a group, one less than 2^ratio
    assign group_last = COUNT_WIDTH'(((COUNT_WIDTH + 1)'(1) << ratio) - (COUNT_WIDTH + 1)'(1));
    assign group_end = (ratio == '0) || (count[channel] == group_last);

    assign extended_sample = {{MAX_RATIO_LOG2{in_beat.data[DATA_WIDTH-1]}}, in_beat.data};
    assign group_sum = accumulator[channel] + extended_sample;

    // Arithmetic shift of the signed sum rounds toward minus infinity.
    // The headroom bits keep a full group of extreme samples from wrapping
    assign group_mean = group_sum >>> ratio;

    assign decimated_data = (mode == MODE_AVERAGE) ? group_mean[DATA_WIDTH-1:0] : in_beat.data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                count[i] <= '0;
                accumulator[i] <= '0;
            end
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (accept) begin
                if (group_end) begin
                    count[channel] <= '0;
                    accumulator[channel] <= '0;
                    out_valid <= 1'b1;
                end else begin
                    count[channel] <= count[channel] + 1'b1;
                    accumulator[channel] <= group_sum;
                end
            end
        end
    end

    // The closing beat carries its own tag and last flag to the output
    always_ff @(posedge clock) begin
        if (accept && group_end) begin
            out_beat.data <= decimated_data;
            out_beat.tag <= in_beat.tag;
            out_beat.last <= in_beat.last;
        end
    end

endmodule

// File: source/stream_arbiter.sv
/* Round-robin merge of the decimator outputs onto one stream.
   The grant is held while the output stalls and local tags become global channel numbers. */
`timescale 1ns/10ps

module stream_arbiter #(
    parameter int N_STREAMS = 2,
    parameter int N_CHANNELS = 4
) (
    input logic clock,
    input logic reset,
    input logic [N_STREAMS-1:0] in_valid,
    output logic [N_STREAMS-1:0] in_ready,
    input decimation_pkg::sample_beat_t in_beat [N_STREAMS],
    output logic out_valid,
    input logic out_ready,
    output decimation_pkg::sample_beat_t out_beat
);

    import decimation_pkg::*;

    localparam int STREAM_WIDTH = $clog2(N_STREAMS > 1 ? N_STREAMS : 2);

    logic [STREAM_WIDTH-1:0] priority_ptr;
    logic [STREAM_WIDTH-1:0] held_grant;
    logic held;
    logic [STREAM_WIDTH-1:0] next_grant;
    logic [STREAM_WIDTH-1:0] grant;
    logic [STREAM_WIDTH-1:0] after_grant;

    // First valid stream at or after the priority pointer
    always_comb begin
        int candidate;
        logic found;
        next_grant = priority_ptr;
        found = 1'b0;
        for (int i = 0; i < N_STREAMS; i++) begin
            candidate = int'(priority_ptr) + i;
            if (candidate >= N_STREAMS) begin
                candidate = candidate - N_STREAMS;
            end
            if (!found && in_valid[candidate]) begin
                next_grant = STREAM_WIDTH'(candidate);
                found = 1'b1;
            end
        end
    end

    // A stalled output keeps the stream it already shows
    assign grant = held ? held_grant : next_grant;
    assign after_grant = (int'(grant) == N_STREAMS - 1) ? '0 : grant + 1'b1;

    assign out_valid = in_valid[grant];

    always_comb begin
        out_beat = in_beat[grant];
        out_beat.tag = TAG_WIDTH'(int'(grant) * N_CHANNELS + int'(in_beat[grant].tag));
    end

    always_comb begin
        in_ready = '0;
        in_ready[grant] = out_ready;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            priority_ptr <= '0;
            held_grant <= '0;
            held <= 1'b0;
        end else if (out_valid && out_ready) begin
            held <= 1'b0;
            priority_ptr <= after_grant;
        end else if (out_valid) begin
            held <= 1'b1;
            held_grant <= grant;
        end
    end

endmodule

// File: tests/decimation_checker.sv
/* Concurrent assertions on the output handshake of the decimation subsystem.
   The testbench binds it to the top level. */
`timescale 1ns/10ps

module decimation_checker #(
    parameter int N_STREAMS = 2
) (
    input logic clock,
    input logic reset,
    input logic [N_STREAMS-1:0] stream_ready,
    input logic out_valid,
    input logic out_ready,
    input decimation_pkg::sample_beat_t out_beat
);

    // A stalled output beat keeps both its valid and its contents
    stalled_output_stable: assert property (
        @(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("output beat changed while the sink stalled it");

    // Reset clears every decimator output register, so nothing reaches the arbiter
    idle_in_reset: assert property (
        @(posedge clock)
        !reset |=> !out_valid
    ) else $error("out_valid high after a reset cycle");

    // With no output pending every decimator register is empty and can take a beat
    ready_when_idle: assert property (
        @(posedge clock) disable iff (!reset)
        !out_valid |-> (&stream_ready)
    ) else $error("stream_ready low while no output is pending");

endmodule

// File: tests/decimation_subsystem_tb.sv
/* Directed testbench for the decimation subsystem. A per-stream reference model predicts
   every output beat, and a monitor compares the merged output against those predictions. */
`timescale 1ns/10ps

module decimation_subsystem_tb;

    import decimation_pkg::*;

    localparam int N_STREAMS = 2;
    localparam int N_CHANNELS = 4;
    localparam int STREAM_WIDTH = $clog2(N_STREAMS > 1 ? N_STREAMS : 2);

    // About 600 cycles of traffic even with random back-pressure, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    localparam logic [DATA_WIDTH-1:0] SAMPLE_MAX = {1'b0, {(DATA_WIDTH - 1){1'b1}}};
    localparam logic [DATA_WIDTH-1:0] SAMPLE_MIN = {1'b1, {(DATA_WIDTH - 1){1'b0}}};

    logic clock;
    logic reset;
    logic [N_STREAMS-1:0] stream_valid;
    logic [N_STREAMS-1:0] stream_ready;
    sample_beat_t stream_beat [N_STREAMS];
    logic config_write;
    logic [STREAM_WIDTH-1:0] config_stream;
    config_field_t config_field;
    logic [RATIO_WIDTH-1:0] config_value;
    logic out_valid;
    logic out_ready;
    sample_beat_t out_beat;

    // Reference model, one group state per stream and channel
    int model_ratio [N_STREAMS];
    decimation_mode_t model_mode [N_STREAMS];
    int model_count [N_STREAMS][N_CHANNELS];
    longint model_sum [N_STREAMS][N_CHANNELS];
    sample_beat_t expected_q [$];

    logic backpressure = 1'b0;
    logic previous_stall = 1'b0;
    int last_stream = N_STREAMS - 1;
    int cycle_count = 0;

    decimation_subsystem #(
        .N_STREAMS(N_STREAMS),
        .N_CHANNELS(N_CHANNELS)
    ) decimation_subsystem_inst (
        .clock(clock),
        .reset(reset),
        .stream_valid(stream_valid),
        .stream_ready(stream_ready),
        .stream_beat(stream_beat),
        .config_write(config_write),
        .config_stream(config_stream),
        .config_field(config_field),
        .config_value(config_value),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_beat(out_beat)
    );

    bind decimation_subsystem decimation_checker #(
        .N_STREAMS(N_STREAMS)
    ) decimation_checker_inst (
        .clock(clock),
        .reset(reset),
        .stream_ready(stream_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_beat(out_beat)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // The sink stalls on about one cycle in four while back-pressure is on
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            if (backpressure) begin
                out_ready = ($urandom_range(3) != 0);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    function automatic longint floor_div(input longint value, input longint divisor);
        longint quotient;
        quotient = value / divisor;
        // Division truncates toward zero, so negative values with a remainder step down once
        if ((value % divisor != 0) && (value < 0)) begin
            quotient = quotient - 1;
        end
        return quotient;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_sample();
        int pick;
        pick = $urandom_range(7);
        if (pick == 0) begin
            return SAMPLE_MAX;
        end else if (pick == 1) begin
            return SAMPLE_MIN;
        end
        return DATA_WIDTH'($urandom);
    endfunction

    task automatic clear_model();
        for (int s = 0; s < N_STREAMS; s++) begin
            model_ratio[s] = 0;
            model_mode[s] = MODE_SAMPLE;
            for (int c = 0; c < N_CHANNELS; c++) begin
                model_count[s][c] = 0;
                model_sum[s][c] = 0;
            end
        end
    endtask

    // Closes a group after 2^ratio beats of one channel and queues the beat it yields
    task automatic model_accept(input int s, input sample_beat_t beat);
        int c;
        longint group_len;
        sample_beat_t expected;
        c = int'(beat.tag);
        group_len = longint'(1) << model_ratio[s];
        model_sum[s][c] += longint'($signed(beat.data));
        model_count[s][c] += 1;
        if (model_count[s][c] == group_len) begin
            if (model_mode[s] == MODE_AVERAGE) begin
                expected.data = DATA_WIDTH'(floor_div(model_sum[s][c], group_len));
            end else begin
                expected.data = beat.data;
            end
            expected.tag = TAG_WIDTH'(s * N_CHANNELS + c);
            expected.last = beat.last;
            expected_q.push_back(expected);
            model_count[s][c] = 0;
            model_sum[s][c] = 0;
        end
    endtask

    task automatic write_config(input int s, input config_field_t field, input int value);
        config_write = 1'b1;
        config_stream = STREAM_WIDTH'(s);
        config_field = field;
        config_value = RATIO_WIDTH'(value);
        @(posedge clock);
        #1;
        config_write = 1'b0;
        if (field == FIELD_RATIO) begin
            model_ratio[s] = (value > MAX_RATIO_LOG2) ? MAX_RATIO_LOG2 : value;
        end else begin
            model_mode[s] = value[0] ? MODE_AVERAGE : MODE_SAMPLE;
        end
    endtask

    task automatic configure_stream(input int s, input int ratio, input decimation_mode_t mode);
        write_config(s, FIELD_RATIO, ratio);
        write_config(s, FIELD_MODE, int'(mode));
    endtask

    // Presents one beat and holds it until the decimator takes it
    task automatic send_beat(input int s, input int channel, input logic [DATA_WIDTH-1:0] data,
                             input logic last);
        sample_beat_t beat;
        beat.data = data;
        beat.tag = TAG_WIDTH'(channel);
        beat.last = last;
        stream_beat[s] = beat;
        stream_valid[s] = 1'b1;
        do begin
            @(posedge clock);
        end while (!stream_ready[s]);
        model_accept(s, beat);
        #1;
        stream_valid[s] = 1'b0;
    endtask

    // Whole groups on the first few channels, interleaved in random order
    task automatic send_groups(input int s, input int channels, input int groups);
        int remaining [N_CHANNELS];
        int group_len;
        int total;
        int channel;
        group_len = 1 << model_ratio[s];
        total = channels * groups * group_len;
        for (int c = 0; c < N_CHANNELS; c++) begin
            remaining[c] = (c < channels) ? groups * group_len : 0;
        end
        for (int n = 0; n < total; n++) begin
            channel = $urandom_range(channels - 1);
            while (remaining[channel] == 0) begin
                channel = (channel + 1) % channels;
            end
            remaining[channel]--;
            send_beat(s, channel, random_sample(), 1'($urandom));
        end
    endtask

    task automatic wait_for_drain();
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        #1;
        check_value("out_valid", out_valid, 0);
    endtask

    task automatic pass_through_after_reset();
        check_value("out_valid", out_valid, 0);
        check_value("stream_ready", stream_ready, {N_STREAMS{1'b1}});
        for (int s = 0; s < N_STREAMS; s++) begin
            send_groups(s, N_CHANNELS, 4);
        end
        wait_for_drain();
    endtask

    task automatic keep_closing_samples();
        configure_stream(0, 3, MODE_SAMPLE);
        send_groups(0, N_CHANNELS, 2);
        wait_for_drain();
    endtask

    task automatic average_signed_groups();
        configure_stream(1, 2, MODE_AVERAGE);
        // Full-scale groups of both signs, then a small negative sum that has to round down
        repeat (4) send_beat(1, 0, SAMPLE_MAX, 1'b0);
        repeat (4) send_beat(1, 1, SAMPLE_MIN, 1'b1);
        send_beat(1, 2, '1, 1'b0);
        repeat (3) send_beat(1, 2, '0, 1'b0);
        send_groups(1, N_CHANNELS, 4);
        wait_for_drain();
    endtask

    task automatic follow_last_flag();
        configure_stream(0, 1, MODE_SAMPLE);
        send_beat(0, 3, 16'd5, 1'b0);
        send_beat(0, 3, 16'd6, 1'b1);
        send_beat(0, 3, 16'd7, 1'b1);
        send_beat(0, 3, 16'd8, 1'b0);
        wait_for_drain();
    endtask

    task automatic merge_under_backpressure();
        configure_stream(0, 1, MODE_AVERAGE);
        configure_stream(1, 0, MODE_SAMPLE);
        backpressure = 1'b1;
        fork
            send_groups(0, N_CHANNELS, 8);
            send_groups(1, N_CHANNELS, 16);
        join
        wait_for_drain();
        backpressure = 1'b0;
    endtask

    task automatic isolate_stream_config();
        // The 3-bit value field tops out at the largest ratio, 128 beats per group
        configure_stream(0, 7, MODE_SAMPLE);
        configure_stream(1, 2, MODE_AVERAGE);
        fork
            send_groups(0, 1, 1);
            send_groups(1, N_CHANNELS, 2);
        join
        wait_for_drain();
        // Stream 0 is retuned, stream 1 keeps its ratio and mode
        configure_stream(0, 1, MODE_AVERAGE);
        fork
            send_groups(0, N_CHANNELS, 2);
            send_groups(1, N_CHANNELS, 2);
        join
        wait_for_drain();
    endtask

    // Each accepted output must match the oldest prediction for its global tag
    always @(posedge clock) begin
        int index;
        int stream;
        if (reset && out_valid && out_ready) begin
            index = -1;
            for (int i = 0; i < expected_q.size(); i++) begin
                if (index < 0 && expected_q[i].tag == out_beat.tag) begin
                    index = i;
                end
            end
            if (index < 0) begin
                $display("unexpected output beat with tag %0d at %0t", out_beat.tag, $time);
                stop_run();
            end else begin
                check_value("out_beat.data", $signed(out_beat.data),
                            $signed(expected_q[index].data));
                check_value("out_beat.last", out_beat.last, expected_q[index].last);
                expected_q.delete(index);
                stream = int'(out_beat.tag) / N_CHANNELS;
                // A fresh grant with every stream pending goes to the one after the last winner
                if (!previous_stall && (&decimation_subsystem_inst.dec_valid)) begin
                    check_value("granted stream", stream, (last_stream + 1) % N_STREAMS);
                end
                last_stream = stream;
            end
        end
    end

    always @(posedge clock) begin
        previous_stall <= reset && out_valid && !out_ready;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped by the timeout after %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    initial begin
        void'($urandom(32'h1bb9_5d50));
        reset = 1'b0;
        stream_valid = '0;
        for (int s = 0; s < N_STREAMS; s++) begin
            stream_beat[s] = '0;
        end
        config_write = 1'b0;
        config_stream = '0;
        config_field = FIELD_RATIO;
        config_value = '0;
        clear_model();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b1;
        pass_through_after_reset();
        keep_closing_samples();
        average_signed_groups();
        follow_last_flag();
        merge_under_backpressure();
        isolate_stream_config();
        if (expected_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d predicted output beats never appeared", expected_q.size());
            stop_run();
        end
    end

endmodule
